// ==== source/slave_agent_pkg.sv ====
// Shared packet and tracking-record definitions for the slave agent
// Imported by every agent module that touches packet or record fields
package slave_agent_pkg;

  // Payload widths with a meaning of their own
  typedef logic [31:0] data_t;
  typedef logic [15:0] addr_t;
  typedef logic [3:0]  byteen_t;
  typedef logic [2:0]  id_t;
  // Up to 16 bytes, so the top bit is needed for a full burst
  typedef logic [4:0]  byte_cnt_t;

  localparam int SYMBOLS   = 4;
  localparam int MAX_BEATS = 4;

  // ------------------------------------------------------------
  // Command and response packet layout
  // ------------------------------------------------------------
  typedef logic [65:0] pkt_t;

  localparam int PKT_DATA_L      = 0;
  localparam int PKT_DATA_H      = 31;
  localparam int PKT_ADDR_L      = 32;
  localparam int PKT_ADDR_H      = 47;
  localparam int PKT_BYTEEN_L    = 48;
  localparam int PKT_BYTEEN_H    = 51;
  localparam int PKT_TRANS_READ  = 52;
  localparam int PKT_TRANS_WRITE = 53;
  localparam int PKT_TRANS_COMPRESSED_READ = 54;
  localparam int PKT_SRC_ID_L    = 55;
  localparam int PKT_SRC_ID_H    = 57;
  localparam int PKT_DEST_ID_L   = 58;
  localparam int PKT_DEST_ID_H   = 60;
  localparam int PKT_BYTE_CNT_L  = 61;
  localparam int PKT_BYTE_CNT_H  = 65;

  // ------------------------------------------------------------
  // Tracking record kept for every accepted read
  // ------------------------------------------------------------
  typedef logic [34:0] rinfo_t;

  localparam int RINFO_ADDR_L     = 0;
  localparam int RINFO_ADDR_H     = 15;
  localparam int RINFO_BYTEEN_L   = 16;
  localparam int RINFO_BYTEEN_H   = 19;
  localparam int RINFO_SRC_ID_L   = 20;
  localparam int RINFO_SRC_ID_H   = 22;
  localparam int RINFO_DEST_ID_L  = 23;
  localparam int RINFO_DEST_ID_H  = 25;
  localparam int RINFO_BYTE_CNT_L = 26;
  localparam int RINFO_BYTE_CNT_H = 30;
  localparam int RINFO_COMPRESSED = 31;
  localparam int RINFO_SUPPRESSED = 32;
  // Packet markers of the command, carried along to frame the response
  localparam int RINFO_SOP        = 33;
  localparam int RINFO_EOP        = 34;

  // Response-side burst expansion
  typedef enum logic {UNC_IDLE, UNC_BURST} unc_state_t;

endpackage

// ==== source/sync_fifo.sv ====
// Single-clock FIFO built from a register array. A push shows at the head
// one cycle later. Pushes while full and pops while empty are dropped
module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] head_data,
  output logic             not_empty,
  output logic             full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push, do_pop;

  assign do_push = push & ~full;
  assign do_pop  = pop & not_empty;

  // Storage holds payload only
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap by hand so DEPTH need not be a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign head_data = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign full      = (count == CNT_W'(DEPTH));

endmodule

// ==== source/cmd_decoder.sv ====
// Command side of the agent. Purely combinational: splits the packet,
// drives the slave port and cp_ready, and forms the tracking record for reads
module cmd_decoder import slave_agent_pkg::*; (
  input  logic       cp_valid,
  output logic       cp_ready,
  input  pkt_t       cp_data,
  input  logic       cp_startofpacket,
  input  logic       cp_endofpacket,
  input  logic       m0_waitrequest,
  input  logic       track_full,
  output addr_t      m0_address,
  output logic [2:0] m0_burstcount,
  output byteen_t    m0_byteenable,
  output logic       m0_read,
  output logic       m0_write,
  output data_t      m0_writedata,
  output logic       track_push,
  output rinfo_t     track_data
);

  byteen_t   cmd_byteen;
  byte_cnt_t cmd_byte_cnt;
  logic      cmd_compressed, cmd_is_read, byteen_asserted;

  assign cmd_byteen     = cp_data[PKT_BYTEEN_H:PKT_BYTEEN_L];
  assign cmd_byte_cnt   = cp_data[PKT_BYTE_CNT_H:PKT_BYTE_CNT_L];
  assign cmd_compressed = cp_data[PKT_TRANS_COMPRESSED_READ];
  // A compressed read is a read even if the plain read flag is clear
  assign cmd_is_read    = cp_data[PKT_TRANS_READ] | cmd_compressed;
  // Commands with no byte enabled never reach the slave
  assign byteen_asserted = |cmd_byteen;

  // ------------------------------------------------------------
  // Slave port
  // ------------------------------------------------------------
  assign m0_address    = cp_data[PKT_ADDR_H:PKT_ADDR_L];
  assign m0_byteenable = cmd_byteen;
  assign m0_writedata  = cp_data[PKT_DATA_H:PKT_DATA_L];
  assign m0_read  = cp_valid & ~track_full & byteen_asserted & cmd_is_read;
  assign m0_write = cp_valid & ~track_full & byteen_asserted & cp_data[PKT_TRANS_WRITE];
  // Words in the burst, taken from the byte count for compressed reads only
  assign m0_burstcount = cmd_compressed ? cmd_byte_cnt[4:2] : 3'd1;

  // A full tracking FIFO stalls writes too, which keeps the ready path short.
  // Suppressed commands never see waitrequest since the slave is not asked
  assign cp_ready = (~m0_waitrequest | ~byteen_asserted) & ~track_full;

  // ------------------------------------------------------------
  // Tracking record, pushed for every accepted read
  // ------------------------------------------------------------
  assign track_push = cp_valid & cp_ready & cmd_is_read;

  always_comb begin
    track_data = '0;
    track_data[RINFO_ADDR_H:RINFO_ADDR_L]         = cp_data[PKT_ADDR_H:PKT_ADDR_L];
    track_data[RINFO_BYTEEN_H:RINFO_BYTEEN_L]     = cmd_byteen;
    track_data[RINFO_SRC_ID_H:RINFO_SRC_ID_L]     = cp_data[PKT_SRC_ID_H:PKT_SRC_ID_L];
    track_data[RINFO_DEST_ID_H:RINFO_DEST_ID_L]   = cp_data[PKT_DEST_ID_H:PKT_DEST_ID_L];
    track_data[RINFO_BYTE_CNT_H:RINFO_BYTE_CNT_L] = cmd_byte_cnt;
    track_data[RINFO_COMPRESSED] = cmd_compressed;
    // The response side makes zero-data beats for this record
    track_data[RINFO_SUPPRESSED] = ~byteen_asserted;
    // A command is a single beat, so its markers pass straight through
    track_data[RINFO_SOP] = cp_startofpacket;
    track_data[RINFO_EOP] = cp_endofpacket;
  end

endmodule

// ==== source/beat_counter.sv ====
// Address and remaining byte count of the burst being expanded.
// Loaded from the tracking record, stepped once per response beat
module beat_counter import slave_agent_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      cnt_load,
  input  logic      cnt_step,
  input  addr_t     start_addr,
  input  byte_cnt_t start_cnt,
  input  logic      compressed,
  output addr_t     beat_addr,
  output byte_cnt_t remaining,
  output logic      last_beat
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_addr <= '0;
      remaining <= '0;
    end else if (cnt_load) begin
      beat_addr <= start_addr;
      // A plain read is always one word
      remaining <= compressed ? start_cnt : byte_cnt_t'(SYMBOLS);
    end else if (cnt_step) begin
      // Bursts always increment, there is no wrapping
      beat_addr <= beat_addr + addr_t'(SYMBOLS);
      remaining <= remaining - byte_cnt_t'(SYMBOLS);
    end
  end

  // The count includes the current beat, so one word or less means last
  assign last_beat = (remaining <= byte_cnt_t'(SYMBOLS));

endmodule

// ==== source/burst_uncompressor.sv ====
// Walks the tracking FIFO one record at a time and sequences the response
// beats of each record. Loads the beat counter, steps it, pops the record
module burst_uncompressor import slave_agent_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   track_not_empty,
  input  rinfo_t track_head,
  input  logic   last_beat,
  input  logic   beat_taken,
  input  logic   rdata_not_empty,
  output logic   track_pop,
  output logic   cnt_load,
  output logic   cnt_step,
  output logic   beat_pending,
  output logic   beat_first,
  output logic   beat_suppressed
);

  unc_state_t state, state_nxt;
  logic       rec_suppressed;

  assign rec_suppressed = track_head[RINFO_SUPPRESSED];

  // ------------------------------------------------------------
  // FSM: one load cycle per record, then one beat per handshake
  // ------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    cnt_load  = 1'b0;
    track_pop = 1'b0;
    case (state)
      UNC_IDLE: begin
        if (track_not_empty) begin
          cnt_load  = 1'b1;
          state_nxt = UNC_BURST;
        end
      end
      UNC_BURST: begin
        // The record leaves the FIFO only with its final beat
        if (beat_taken && last_beat) begin
          track_pop = 1'b1;
          state_nxt = UNC_IDLE;
        end
      end
      default: state_nxt = UNC_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= UNC_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Set on load and cleared once the opening beat has gone out
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_first <= 1'b0;
    end else if (cnt_load) begin
      beat_first <= 1'b1;
    end else if (beat_taken) begin
      beat_first <= 1'b0;
    end
  end

  // Suppressed beats need no slave data, real ones wait for the read FIFO
  assign beat_pending    = (state == UNC_BURST) & (rec_suppressed | rdata_not_empty);
  assign beat_suppressed = rec_suppressed;
  // No step after the last beat, the next record reloads the counter
  assign cnt_step        = beat_taken & ~last_beat;

endmodule

// ==== source/resp_builder.sv ====
// Assembles response packets from the current beat, the tracking record and
// the read data, and runs the valid/ready handshake on the response source
module resp_builder import slave_agent_pkg::*; (
  input  logic      beat_pending,
  input  logic      beat_first,
  input  logic      beat_suppressed,
  input  logic      last_beat,
  input  addr_t     beat_addr,
  input  byte_cnt_t remaining,
  input  rinfo_t    track_head,
  input  data_t     rdata_head,
  input  logic      rp_ready,
  output logic      rp_valid,
  output pkt_t      rp_data,
  output logic      rp_startofpacket,
  output logic      rp_endofpacket,
  output logic      rdata_pop,
  output logic      beat_taken
);

  // Inputs only move on a handshake, so the outputs hold while stalled
  assign rp_valid   = beat_pending;
  assign beat_taken = beat_pending & rp_ready;
  // Suppressed beats have nothing in the read-data FIFO
  assign rdata_pop  = beat_taken & ~beat_suppressed;

  // Framing follows the command markers stored in the record
  assign rp_startofpacket = beat_first & track_head[RINFO_SOP];
  assign rp_endofpacket   = last_beat & track_head[RINFO_EOP];

  always_comb begin
    rp_data = '0;
    rp_data[PKT_DATA_H:PKT_DATA_L]         = beat_suppressed ? '0 : rdata_head;
    rp_data[PKT_ADDR_H:PKT_ADDR_L]         = beat_addr;
    rp_data[PKT_BYTEEN_H:PKT_BYTEEN_L]     = track_head[RINFO_BYTEEN_H:RINFO_BYTEEN_L];
    // Every response is an uncompressed read beat
    rp_data[PKT_TRANS_READ]                = 1'b1;
    rp_data[PKT_TRANS_WRITE]               = 1'b0;
    rp_data[PKT_TRANS_COMPRESSED_READ]     = 1'b0;
    // IDs swap so the response routes back to the requester
    rp_data[PKT_SRC_ID_H:PKT_SRC_ID_L]     = track_head[RINFO_DEST_ID_H:RINFO_DEST_ID_L];
    rp_data[PKT_DEST_ID_H:PKT_DEST_ID_L]   = track_head[RINFO_SRC_ID_H:RINFO_SRC_ID_L];
    rp_data[PKT_BYTE_CNT_H:PKT_BYTE_CNT_L] = remaining;
  end

endmodule

// ==== source/slave_agent_top.sv ====
// Slave agent top level: command packets in, slave accesses out, read
// responses back as packets. RESP_DEPTH sets how many reads may be in flight
module slave_agent_top import slave_agent_pkg::*; #(
  parameter int RESP_DEPTH = 4
) (
  input  logic      clk,
  input  logic      arst_n,
  // Command sink
  input  logic      cp_valid,
  output logic      cp_ready,
  input  pkt_t      cp_data,
  input  logic      cp_startofpacket,
  input  logic      cp_endofpacket,
  // Memory-mapped slave port
  output addr_t     m0_address,
  output logic [2:0] m0_burstcount,
  output byteen_t   m0_byteenable,
  output logic      m0_read,
  output logic      m0_write,
  output data_t     m0_writedata,
  input  logic      m0_waitrequest,
  input  data_t     m0_readdata,
  input  logic      m0_readdatavalid,
  // Response source
  output logic      rp_valid,
  input  logic      rp_ready,
  output pkt_t      rp_data,
  output logic      rp_startofpacket,
  output logic      rp_endofpacket
);

  // ------------------------------------------------------------
  // Internal wiring
  // ------------------------------------------------------------
  logic      track_push, track_pop, track_full, track_not_empty;
  rinfo_t    track_data, track_head;
  logic      rdata_pop, rdata_not_empty;
  data_t     rdata_head;
  logic      cnt_load, cnt_step, last_beat;
  addr_t     beat_addr;
  byte_cnt_t remaining;
  logic      beat_pending, beat_first, beat_suppressed, beat_taken;

  cmd_decoder u_cmd_decoder (
    .cp_valid, .cp_ready, .cp_data, .cp_startofpacket, .cp_endofpacket,
    .m0_waitrequest, .track_full,
    .m0_address, .m0_burstcount, .m0_byteenable, .m0_read, .m0_write, .m0_writedata,
    .track_push, .track_data
  );

  // One record per accepted read, popped after its last response beat
  sync_fifo #(.WIDTH($bits(rinfo_t)), .DEPTH(RESP_DEPTH)) track_fifo (
    .clk, .arst_n, .push(track_push), .push_data(track_data), .pop(track_pop),
    .head_data(track_head), .not_empty(track_not_empty), .full(track_full)
  );

  // Sized for every beat of every outstanding read, so it never fills
  sync_fifo #(.WIDTH($bits(data_t)), .DEPTH(RESP_DEPTH * MAX_BEATS)) rdata_fifo (
    .clk, .arst_n, .push(m0_readdatavalid), .push_data(m0_readdata), .pop(rdata_pop),
    .head_data(rdata_head), .not_empty(rdata_not_empty), .full()
  );

  burst_uncompressor u_burst_uncompressor (
    .clk, .arst_n, .track_not_empty, .track_head, .last_beat, .beat_taken,
    .rdata_not_empty, .track_pop, .cnt_load, .cnt_step, .beat_pending, .beat_first,
    .beat_suppressed
  );

  beat_counter u_beat_counter (
    .clk, .arst_n, .cnt_load, .cnt_step,
    .start_addr(track_head[RINFO_ADDR_H:RINFO_ADDR_L]),
    .start_cnt(track_head[RINFO_BYTE_CNT_H:RINFO_BYTE_CNT_L]),
    .compressed(track_head[RINFO_COMPRESSED]),
    .beat_addr, .remaining, .last_beat
  );

  resp_builder u_resp_builder (
    .beat_pending, .beat_first, .beat_suppressed, .last_beat, .beat_addr, .remaining,
    .track_head, .rdata_head, .rp_ready, .rp_valid, .rp_data, .rp_startofpacket,
    .rp_endofpacket, .rdata_pop, .beat_taken
  );

endmodule

// ==== verif/tb_clock.sv ====
// Free-running testbench clock, 100 ns period
// Instantiated once by the testbench top
module tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
  end

  // Half period of 50 ns
  always #50 clk = ~clk;

endmodule

// ==== verif/slave_agent_asserts.sv ====
// Protocol checks on the agent's response source and slave port.
// Bound into every slave_agent_top instance at the end of this file
module slave_agent_asserts import slave_agent_pkg::*; (
  input logic    clk,
  input logic    arst_n,
  input logic    rp_valid,
  input logic    rp_ready,
  input pkt_t    rp_data,
  input logic    m0_read,
  input logic    m0_write,
  input byteen_t m0_byteenable
);

  timeunit 1ns;
  timeprecision 100ps;

  // A stalled beat keeps its valid and its payload until it is taken
  rp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rp_valid && !rp_ready |=> rp_valid && $stable(rp_data))
    else $error("response beat changed while rp_ready was low");

  // One command at a time on the slave port
  rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(m0_read && m0_write))
    else $error("m0_read and m0_write asserted together");

  // Commands without byte enables are answered locally
  no_zero_be: assert property (@(posedge clk) disable iff (!arst_n)
    (m0_read || m0_write) |-> (m0_byteenable != '0))
    else $error("slave access made with zero byte enables");

  // Nothing is pending on the first edge out of reset
  rp_idle_after_reset: assert property (@(posedge clk)
    $rose(arst_n) |-> !rp_valid)
    else $error("rp_valid high right after reset");

endmodule

bind slave_agent_top slave_agent_asserts u_asserts (
  .clk(clk), .arst_n(arst_n), .rp_valid(rp_valid), .rp_ready(rp_ready), .rp_data(rp_data),
  .m0_read(m0_read), .m0_write(m0_write), .m0_byteenable(m0_byteenable)
);

// ==== verif/tb_top.sv ====
// Directed testbench for the slave agent. Holds a small slave memory model,
// builds expected response beats from the packet rules and compares them
// with what the agent sends back. Closes with one result line
module tb_top import slave_agent_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam bit [31:0] SEED      = 32'he8a8_b0bc;
  localparam int        TIMEOUT   = 3000;
  localparam data_t     DATA_BASE = 32'hA500_0000;

  logic       clk;
  logic       arst_n = 1'b0;
  logic       cp_valid = 1'b0;
  logic       cp_ready;
  pkt_t       cp_data = '0;
  logic       cp_sop = 1'b0;
  logic       cp_eop = 1'b0;
  addr_t      m0_address;
  logic [2:0] m0_burstcount;
  byteen_t    m0_byteenable;
  logic       m0_read, m0_write;
  data_t      m0_writedata;
  logic       m0_waitrequest = 1'b0;
  data_t      m0_readdata = '0;
  logic       m0_readdatavalid = 1'b0;
  logic       rp_valid, rp_sop, rp_eop;
  logic       rp_ready = 1'b1;
  pkt_t       rp_data;

  // Test control and bookkeeping
  logic       random_ready = 1'b0;
  int         cycles = 0;
  int         value_errs = 0;
  int         other_errs = 0;
  string      cur_test = "reset";
  int         read_cycles = 0;
  int         writes_issued = 0;
  int         gap = 0;
  logic [2:0] last_burst = '0;
  addr_t      last_addr = '0;
  data_t      last_wdata = '0;
  byteen_t    last_be = '0;
  data_t      rd_q[$];
  pkt_t       exp_pkt[$];
  pkt_t       got_pkt[$];
  logic [1:0] exp_frame[$];
  logic [1:0] got_frame[$];

  tb_clock u_clock (.clk(clk));

  slave_agent_top #(.RESP_DEPTH(4)) dut (
    .clk(clk), .arst_n(arst_n),
    .cp_valid(cp_valid), .cp_ready(cp_ready), .cp_data(cp_data),
    .cp_startofpacket(cp_sop), .cp_endofpacket(cp_eop),
    .m0_address(m0_address), .m0_burstcount(m0_burstcount),
    .m0_byteenable(m0_byteenable), .m0_read(m0_read), .m0_write(m0_write),
    .m0_writedata(m0_writedata), .m0_waitrequest(m0_waitrequest),
    .m0_readdata(m0_readdata), .m0_readdatavalid(m0_readdatavalid),
    .rp_valid(rp_valid), .rp_ready(rp_ready), .rp_data(rp_data),
    .rp_startofpacket(rp_sop), .rp_endofpacket(rp_eop)
  );

  // ------------------------------------------------------------
  // Watchdog set well above the length of all five tests
  // ------------------------------------------------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Slave model and response monitor
  // ------------------------------------------------------------
  // Handshakes are sampled mid-cycle, where every input and output is settled
  always @(negedge clk) begin
    // Any cycle with m0_read high counts, whether or not the slave stalls it
    if (arst_n && m0_read) begin
      read_cycles++;
    end
    if (arst_n && (m0_read || m0_write) && !m0_waitrequest) begin
      last_addr  = m0_address;
      last_wdata = m0_writedata;
      last_be    = m0_byteenable;
      last_burst = m0_burstcount;
      if (m0_write) begin
        writes_issued++;
      end
      if (m0_read) begin
        // Read data is the base pattern plus the word address of each beat
        for (int i = 0; i < int'(m0_burstcount); i++) begin
          rd_q.push_back(DATA_BASE + data_t'(m0_address >> 2) + data_t'(i));
        end
      end
    end
    if (arst_n && rp_valid && rp_ready) begin
      got_pkt.push_back(rp_data);
      got_frame.push_back({rp_sop, rp_eop});
    end
  end

  // Each beat comes back 1 to 3 cycles after the one before it
  always @(posedge clk) begin
    m0_readdatavalid <= 1'b0;
    if (gap > 0) begin
      gap = gap - 1;
    end else if (rd_q.size() > 0) begin
      m0_readdatavalid <= 1'b1;
      m0_readdata      <= rd_q.pop_front();
      gap = $urandom_range(2, 0);
    end
  end

  // Random waitrequest from the slave and random stalls on the response side
  always @(posedge clk) begin
    m0_waitrequest <= ($urandom_range(3, 0) == 0);
    rp_ready       <= random_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
  end

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_be(input string what, input byteen_t exp, input byteen_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_id(input string what, input id_t exp, input id_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_cnt(input string what, input byte_cnt_t exp, input byte_cnt_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // ------------------------------------------------------------
  // Command and expectation helpers
  // ------------------------------------------------------------
  function automatic pkt_t make_cmd(input logic rd, input logic comp, input addr_t a,
                                    input byteen_t be, input id_t src, input id_t dst,
                                    input byte_cnt_t cnt, input data_t wdata);
    pkt_t p;
    p = '0;
    p[PKT_DATA_H:PKT_DATA_L]         = wdata;
    p[PKT_ADDR_H:PKT_ADDR_L]         = a;
    p[PKT_BYTEEN_H:PKT_BYTEEN_L]     = be;
    p[PKT_TRANS_READ]                = rd;
    p[PKT_TRANS_WRITE]               = ~rd;
    p[PKT_TRANS_COMPRESSED_READ]     = comp;
    p[PKT_SRC_ID_H:PKT_SRC_ID_L]     = src;
    p[PKT_DEST_ID_H:PKT_DEST_ID_L]   = dst;
    p[PKT_BYTE_CNT_H:PKT_BYTE_CNT_L] = cnt;
    return p;
  endfunction

  // Queues the response beats that a read command must produce
  task automatic expect_read(input pkt_t cmd);
    int    nbeats;
    logic  supp;
    addr_t a;
    pkt_t  r;
    supp   = (cmd[PKT_BYTEEN_H:PKT_BYTEEN_L] == '0);
    nbeats = 1;
    if (cmd[PKT_TRANS_COMPRESSED_READ]) begin
      nbeats = int'(cmd[PKT_BYTE_CNT_H:PKT_BYTE_CNT_L]) / SYMBOLS;
    end
    for (int i = 0; i < nbeats; i++) begin
      a = cmd[PKT_ADDR_H:PKT_ADDR_L] + addr_t'(SYMBOLS * i);
      r = '0;
      r[PKT_DATA_H:PKT_DATA_L]         = supp ? '0 : DATA_BASE + data_t'(a >> 2);
      r[PKT_ADDR_H:PKT_ADDR_L]         = a;
      r[PKT_BYTEEN_H:PKT_BYTEEN_L]     = cmd[PKT_BYTEEN_H:PKT_BYTEEN_L];
      r[PKT_TRANS_READ]                = 1'b1;
      r[PKT_SRC_ID_H:PKT_SRC_ID_L]     = cmd[PKT_DEST_ID_H:PKT_DEST_ID_L];
      r[PKT_DEST_ID_H:PKT_DEST_ID_L]   = cmd[PKT_SRC_ID_H:PKT_SRC_ID_L];
      r[PKT_BYTE_CNT_H:PKT_BYTE_CNT_L] = byte_cnt_t'((nbeats - i) * SYMBOLS);
      exp_pkt.push_back(r);
      exp_frame.push_back({i == 0, i == nbeats - 1});
    end
  endtask

  // Holds the command until the agent takes it
  task automatic send_cmd(input pkt_t p);
    @(posedge clk);
    cp_valid <= 1'b1;
    cp_data  <= p;
    cp_sop   <= 1'b1;
    cp_eop   <= 1'b1;
    @(negedge clk);
    while (!cp_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    cp_valid <= 1'b0;
  endtask

  // Waits for every expected beat, then compares field by field in order
  task automatic check_responses();
    pkt_t       e, g;
    logic [1:0] ef, gf;
    while (got_pkt.size() < exp_pkt.size()) begin
      @(posedge clk);
    end
    // A few more cycles so that a surplus beat would show up
    repeat (4) @(posedge clk);
    if (got_pkt.size() != exp_pkt.size()) begin
      other_errs++;
      $display("%s: %0d response beats arrived where %0d were due",
               cur_test, got_pkt.size(), exp_pkt.size());
    end
    while (exp_pkt.size() > 0 && got_pkt.size() > 0) begin
      e  = exp_pkt.pop_front();
      g  = got_pkt.pop_front();
      ef = exp_frame.pop_front();
      gf = got_frame.pop_front();
      check_data("data", e[PKT_DATA_H:PKT_DATA_L], g[PKT_DATA_H:PKT_DATA_L]);
      check_addr("address", e[PKT_ADDR_H:PKT_ADDR_L], g[PKT_ADDR_H:PKT_ADDR_L]);
      check_be("byteenable", e[PKT_BYTEEN_H:PKT_BYTEEN_L], g[PKT_BYTEEN_H:PKT_BYTEEN_L]);
      check_id("source id", e[PKT_SRC_ID_H:PKT_SRC_ID_L], g[PKT_SRC_ID_H:PKT_SRC_ID_L]);
      check_id("dest id", e[PKT_DEST_ID_H:PKT_DEST_ID_L], g[PKT_DEST_ID_H:PKT_DEST_ID_L]);
      check_cnt("byte count", e[PKT_BYTE_CNT_H:PKT_BYTE_CNT_L],
                g[PKT_BYTE_CNT_H:PKT_BYTE_CNT_L]);
      check_bit("read flag", 1'b1, g[PKT_TRANS_READ]);
      check_bit("write flag", 1'b0, g[PKT_TRANS_WRITE]);
      check_bit("compressed flag", 1'b0, g[PKT_TRANS_COMPRESSED_READ]);
      check_bit("startofpacket", ef[1], gf[1]);
      check_bit("endofpacket", ef[0], gf[0]);
    end
    exp_pkt.delete();
    got_pkt.delete();
    exp_frame.delete();
    got_frame.delete();
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_write();
    int n;
    cur_test = "test_write";
    n = writes_issued;
    send_cmd(make_cmd(1'b0, 1'b0, 16'h0120, 4'hF, 3'd1, 3'd2, 5'd4, 32'hDEAD_BEEF));
    check_bit("m0_write accepted", 1'b1, writes_issued == n + 1);
    check_addr("m0_address", 16'h0120, last_addr);
    check_data("m0_writedata", 32'hDEAD_BEEF, last_wdata);
    check_be("m0_byteenable", 4'hF, last_be);
    // Writes are never answered
    repeat (10) @(posedge clk);
    if (got_pkt.size() != 0) begin
      other_errs++;
      $display("%s: a write produced a response beat", cur_test);
      got_pkt.delete();
      got_frame.delete();
    end
  endtask

  task automatic test_single_read();
    pkt_t p;
    cur_test = "test_single_read";
    p = make_cmd(1'b1, 1'b0, 16'h0040, 4'hF, 3'd3, 3'd5, 5'd4, '0);
    expect_read(p);
    send_cmd(p);
    check_cnt("m0_burstcount", 5'd1, byte_cnt_t'(last_burst));
    check_responses();
  endtask

  task automatic test_suppressed_read();
    pkt_t p;
    int   n;
    cur_test = "test_suppressed_read";
    n = read_cycles;
    p = make_cmd(1'b1, 1'b0, 16'h0088, 4'h0, 3'd6, 3'd1, 5'd4, '0);
    expect_read(p);
    send_cmd(p);
    check_responses();
    check_bit("m0_read raised", 1'b0, read_cycles != n);
  endtask

  task automatic test_burst_read();
    pkt_t p;
    cur_test = "test_burst_read";
    p = make_cmd(1'b1, 1'b1, 16'h0200, 4'hF, 3'd2, 3'd7, 5'd16, '0);
    expect_read(p);
    send_cmd(p);
    check_cnt("m0_burstcount", 5'd4, byte_cnt_t'(last_burst));
    check_responses();
  endtask

  task automatic test_backpressure();
    pkt_t      p;
    int        kind;
    logic      comp;
    byteen_t   be;
    byte_cnt_t cnt;
    cur_test = "test_backpressure";
    @(negedge clk);
    random_ready = 1'b1;
    // Kind 0 is a single read, 1 a burst, 2 a suppressed read of either size
    for (int i = 0; i < 8; i++) begin
      kind = (i < 3) ? i : $urandom_range(2, 0);
      comp = (kind == 1) || (kind == 2 && i[0]);
      be   = (kind == 2) ? 4'h0 : byteen_t'($urandom_range(15, 1));
      cnt  = comp ? byte_cnt_t'(SYMBOLS * $urandom_range(4, 2)) : 5'd4;
      p = make_cmd(1'b1, comp, addr_t'($urandom_range(1023, 0) * 16), be,
                   id_t'($urandom_range(7, 0)), id_t'($urandom_range(7, 0)), cnt, '0);
      expect_read(p);
      send_cmd(p);
    end
    check_responses();
    @(negedge clk);
    random_ready = 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    test_write();
    test_single_read();
    test_suppressed_read();
    test_burst_read();
    test_backpressure();
    $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
source/slave_agent_pkg.sv
source/sync_fifo.sv
source/cmd_decoder.sv
source/beat_counter.sv
source/burst_uncompressor.sv
source/resp_builder.sv
source/slave_agent_top.sv
verif/tb_clock.sv
verif/slave_agent_asserts.sv
verif/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the slave agent testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_top -Mdir obj_dir -o tb_sim -f files.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
